// File: compile.f
fsab_pkg.sv
fsab_req_if.sv
fsab_data_if.sv
fsab_req_fifo.sv
fsab_data_fifo.sv
fsab_mem_ctrl.sv
fsab_sim_memory.sv
tb_fsab_sim_memory.sv

// File: run.sh
#!/usr/bin/env bash
# Build the FSAB memory testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module tb_fsab_sim_memory \
	-f compile.f \
	-o sim_fsab
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output="$(./obj_dir/sim_fsab)"
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1

// File: tb_fsab_sim_memory.sv
`timescale 1ns/10ps
`default_nettype none

module tb_fsab_sim_memory import fsab_pkg::*; ();

	localparam int mem_words = 1024;
	localparam int reset_cycles = 8;
	localparam int idle_cycles = 10;
	localparam int num_requests = 14; // requests issued over all tests.
	localparam int wait_limit = 200; // cycles allowed for one beat or for the credits.
	localparam int watchdog_cycles = reset_cycles + idle_cycles + 200 * num_requests;
	localparam logic [31:0] lfsr_taps = 32'h80200003;

	logic clk;
	logic Nrst;
	logic fsabo_valid;
	fsab_mode_t fsabo_mode;
	fsab_did_t fsabo_did;
	fsab_did_t fsabo_subdid;
	fsab_addr_t fsabo_addr;
	fsab_len_t fsabo_len;
	fsab_data_t fsabo_data;
	fsab_mask_t fsabo_mask;
	logic fsabo_credit;
	logic fsabi_valid;
	fsab_did_t fsabi_did;
	fsab_did_t fsabi_subdid;
	fsab_data_t fsabi_data;

	int errors;
	int issued; // requests sent, each one spends a credit.
	int returned = 0; // credit pulses seen on fsabo_credit.
	int rx_next; // next response beat still to be checked.
	logic [31:0] lfsr_state = 32'd73253;
	fsab_data_t model_mem [int];
	fsab_data_t rx_data [$];
	fsab_did_t rx_did [$];
	fsab_did_t rx_subdid [$];

	fsab_sim_memory #(
		.mem_words (mem_words)
	) fsab_sim_memory_i (
		.clk (clk),
		.Nrst (Nrst),
		.fsabo_valid (fsabo_valid),
		.fsabo_mode (fsabo_mode),
		.fsabo_did (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr (fsabo_addr),
		.fsabo_len (fsabo_len),
		.fsabo_data (fsabo_data),
		.fsabo_mask (fsabo_mask),
		.fsabo_credit (fsabo_credit),
		.fsabi_valid (fsabi_valid),
		.fsabi_did (fsabi_did),
		.fsabi_subdid (fsabi_subdid),
		.fsabi_data (fsabi_data)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Both bus outputs are sampled here and only read back at the falling edge.
	always @(posedge clk) begin
		if (Nrst) begin
			if (fsabo_credit) begin
				returned++;
			end
			if (fsabi_valid) begin
				rx_data.push_back(fsabi_data);
				rx_did.push_back(fsabi_did);
				rx_subdid.push_back(fsabi_subdid);
			end
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Watchdog expired, the tests did not finish in %0d cycles", watchdog_cycles);
		$display("Something failed");
		$finish;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ lfsr_taps) : (state >> 1);
	endfunction

	function automatic logic [63:0] rand_bits(input int nbits);
		logic [63:0] value;
		value = '0;
		for (int i = 0; i < nbits; i++) begin
			value = {value[62:0], lfsr_state[0]}; // one step for each bit taken.
			lfsr_state = lfsr_next(lfsr_state);
		end
		return value;
	endfunction

	// Word index wraps at the memory size, as the address bits above it are ignored.
	function automatic int word_of(input fsab_addr_t addr);
		return int'(addr >> fsab_addr_lo) % mem_words;
	endfunction

	function automatic fsab_data_t model_read(input fsab_addr_t addr);
		if (model_mem.exists(word_of(addr))) begin
			return model_mem[word_of(addr)];
		end
		return '0; // memory starts out cleared.
	endfunction

	task automatic model_write(input fsab_addr_t addr, input fsab_data_t word,
			input fsab_mask_t mask);
		fsab_data_t merged;
		merged = model_read(addr);
		for (int b = 0; b < fsab_bytes; b++) begin
			if (mask[b]) begin
				merged[b*8 +: 8] = word[b*8 +: 8];
			end
		end
		model_mem[word_of(addr)] = merged;
	endtask

	function automatic int credits_held();
		return fsab_credits - issued + returned;
	endfunction

	task automatic check_data(input string name, input fsab_data_t got, input fsab_data_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_did(input string name, input fsab_did_t got, input fsab_did_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("ERROR at %0t: %s = %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic wait_credit();
		while (credits_held() == 0) begin
			@(negedge clk);
		end
	endtask

	task automatic issue_write(input fsab_did_t did, input fsab_did_t subdid,
			input fsab_addr_t addr, input fsab_len_t len, input bit full_mask);
		fsab_data_t word;
		fsab_mask_t mask;
		fsab_addr_t beat_addr;
		wait_credit();
		issued++;
		for (int i = 0; i < int'(len); i++) begin
			word = rand_bits(fsab_data_w);
			mask = full_mask ? '1 : fsab_mask_t'(rand_bits(fsab_mask_w));
			beat_addr = addr + fsab_addr_t'(i * fsab_bytes);
			model_write(beat_addr, word, mask);
			@(posedge clk);
			#2;
			fsabo_valid = 1'b1;
			fsabo_mode = FSAB_WRITE;
			fsabo_did = did;
			fsabo_subdid = subdid;
			fsabo_addr = addr; // the header rides along on every beat of the burst.
			fsabo_len = len;
			fsabo_data = word;
			fsabo_mask = mask;
		end
		@(posedge clk);
		#2;
		fsabo_valid = 1'b0;
	endtask

	task automatic issue_read(input fsab_did_t did, input fsab_did_t subdid,
			input fsab_addr_t addr, input fsab_len_t len);
		wait_credit();
		issued++;
		@(posedge clk);
		#2;
		fsabo_valid = 1'b1;
		fsabo_mode = FSAB_READ;
		fsabo_did = did;
		fsabo_subdid = subdid;
		fsabo_addr = addr;
		fsabo_len = len;
		fsabo_data = rand_bits(fsab_data_w); // queued by the memory but never used.
		fsabo_mask = '0;
		@(posedge clk);
		#2;
		fsabo_valid = 1'b0;
	endtask

	task automatic collect_read(input fsab_did_t did, input fsab_did_t subdid,
			input fsab_addr_t addr, input fsab_len_t len);
		int cycles;
		fsab_addr_t beat_addr;
		for (int i = 0; i < int'(len); i++) begin
			cycles = 0;
			while (rx_data.size() <= rx_next && cycles < wait_limit) begin
				@(negedge clk);
				cycles++;
			end
			if (rx_data.size() <= rx_next) begin
				$display("Read beat %0d for device %0d never arrived", i, did);
				errors++;
				return;
			end
			beat_addr = addr + fsab_addr_t'(i * fsab_bytes);
			check_data("fsabi_data", rx_data[rx_next], model_read(beat_addr));
			check_did("fsabi_did", rx_did[rx_next], did);
			check_did("fsabi_subdid", rx_subdid[rx_next], subdid);
			rx_next++;
		end
	endtask

	task automatic wait_credits_back();
		int cycles;
		cycles = 0;
		while (credits_held() != fsab_credits && cycles < wait_limit) begin
			@(negedge clk);
			cycles++;
		end
	endtask

	task automatic test_idle_after_reset();
		repeat (idle_cycles) begin
			@(negedge clk);
			check_count("fsabi_valid", int'(fsabi_valid), 0);
			check_count("fsabo_credit", int'(fsabo_credit), 0);
		end
		issue_read(4'd1, 4'd2, 31'h0000_0100, 4'd1);
		collect_read(4'd1, 4'd2, 31'h0000_0100, 4'd1);
	endtask

	task automatic test_single_word();
		issue_write(4'd2, 4'd3, 31'h0000_0080, 4'd1, 1'b1);
		issue_read(4'd2, 4'd3, 31'h0000_0080, 4'd1);
		collect_read(4'd2, 4'd3, 31'h0000_0080, 4'd1);
	endtask

	task automatic test_masked_burst();
		issue_write(4'd3, 4'd0, 31'h0000_0200, 4'd8, 1'b1);
		issue_write(4'd3, 4'd1, 31'h0000_0200, 4'd8, 1'b0); // merges over the first burst.
		issue_read(4'd3, 4'd2, 31'h0000_0200, 4'd8);
		collect_read(4'd3, 4'd2, 31'h0000_0200, 4'd8);
	endtask

	task automatic test_back_to_back();
		int start_beats;
		wait_credits_back();
		start_beats = rx_data.size();
		issue_write(4'd1, 4'd0, 31'h0000_0300, 4'd2, 1'b1);
		issue_read(4'd2, 4'd5, 31'h0000_0300, 4'd2);
		issue_read(4'd3, 4'd6, 31'h0000_0200, 4'd3);
		issue_read(4'd4, 4'd7, 31'h0000_0308, 4'd1);
		collect_read(4'd2, 4'd5, 31'h0000_0300, 4'd2);
		collect_read(4'd3, 4'd6, 31'h0000_0200, 4'd3);
		collect_read(4'd4, 4'd7, 31'h0000_0308, 4'd1);
		check_count("read beats", rx_data.size() - start_beats, 6);
		wait_credits_back();
		check_count("credits", credits_held(), fsab_credits);
	endtask

	task automatic test_read_tags();
		issue_read(4'd9, 4'd10, 31'h0000_0220, 4'd4);
		issue_read(4'd11, 4'd12, 31'h0000_0200, 4'd4);
		collect_read(4'd9, 4'd10, 31'h0000_0220, 4'd4);
		collect_read(4'd11, 4'd12, 31'h0000_0200, 4'd4);
	endtask

	task automatic test_address_alias();
		issue_write(4'd5, 4'd6, fsab_addr_t'(mem_words * fsab_bytes * 5 + 'h48), 4'd1, 1'b1);
		issue_read(4'd5, 4'd7, 31'h0000_0048, 4'd1);
		collect_read(4'd5, 4'd7, 31'h0000_0048, 4'd1);
	endtask

	initial begin
		errors = 0;
		issued = 0;
		rx_next = 0;
		Nrst = 1'b0;
		fsabo_valid = 1'b0;
		fsabo_mode = FSAB_READ;
		fsabo_did = '0;
		fsabo_subdid = '0;
		fsabo_addr = '0;
		fsabo_len = 4'd1;
		fsabo_data = '0;
		fsabo_mask = '0;
		repeat (reset_cycles) @(posedge clk);
		#2;
		Nrst = 1'b1;
		test_idle_after_reset();
		test_single_word();
		test_masked_burst();
		test_back_to_back();
		test_read_tags();
		test_address_alias();
		wait_credits_back();
		check_count("final credits", credits_held(), fsab_credits);
		check_count("unexpected read beats", rx_data.size(), rx_next);
		$display("Run complete with %0d errors over %0d requests", errors, issued);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: fsab_sim_memory.sv
`timescale 1ns/10ps
`default_nettype none

module fsab_sim_memory import fsab_pkg::*; #(
	parameter int mem_words = 1024
) (
	input wire clk,
	input wire Nrst,

	input wire fsabo_valid,
	input wire fsab_mode_t fsabo_mode,
	input wire fsab_did_t fsabo_did,
	input wire fsab_did_t fsabo_subdid,
	input wire fsab_addr_t fsabo_addr,
	input wire fsab_len_t fsabo_len,
	input wire fsab_data_t fsabo_data,
	input wire fsab_mask_t fsabo_mask,
	output wire fsabo_credit,

	output wire fsabi_valid,
	output wire fsab_did_t fsabi_did,
	output wire fsab_did_t fsabi_subdid,
	output wire fsab_data_t fsabi_data
);

	fsab_req_if req_bus ();
	fsab_data_if data_bus ();

	fsab_req_fifo req_fifo_i (
		.clk (clk),
		.Nrst (Nrst),
		.fsabo_valid (fsabo_valid),
		.fsabo_mode (fsabo_mode),
		.fsabo_did (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr (fsabo_addr),
		.fsabo_len (fsabo_len),
		.fsabo_credit (fsabo_credit),
		.req (req_bus.fifo)
	);

	// Deep enough for every credit to carry a full length burst.
	fsab_data_fifo #(
		.data_depth (fsab_credits * fsab_len_max)
	) data_fifo_i (
		.clk (clk),
		.Nrst (Nrst),
		.fsabo_valid (fsabo_valid),
		.fsabo_data (fsabo_data),
		.fsabo_mask (fsabo_mask),
		.dat (data_bus.fifo)
	);

	fsab_mem_ctrl #(
		.mem_words (mem_words)
	) mem_ctrl_i (
		.clk (clk),
		.Nrst (Nrst),
		.req (req_bus.ctrl),
		.dat (data_bus.ctrl),
		.fsabi_valid (fsabi_valid),
		.fsabi_did (fsabi_did),
		.fsabi_subdid (fsabi_subdid),
		.fsabi_data (fsabi_data)
	);

endmodule

`default_nettype wire

// File: fsab_mem_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module fsab_mem_ctrl import fsab_pkg::*; #(
	parameter int mem_words = 1024
) (
	input wire clk,
	input wire Nrst,
	fsab_req_if.ctrl req,
	fsab_data_if.ctrl dat,
	output logic fsabi_valid,
	output fsab_did_t fsabi_did,
	output fsab_did_t fsabi_subdid,
	output fsab_data_t fsabi_data
);

	localparam int idx_w = $clog2(mem_words);

	typedef logic [idx_w-1:0] word_idx_t;

	mem_state_t state;
	fsab_addr_t addr_r; // address of the next beat after the first.
	fsab_len_t len_rem; // beats left, counting the one in progress.
	fsab_addr_t cur_addr;
	fsab_len_t cur_len;
	word_idx_t cur_idx;
	logic in_load;
	logic wr_beat;
	logic rd_beat;
	logic last_beat;

	fsab_data_t mem [mem_words];

	// High address bits above the array size simply wrap around.
	function automatic word_idx_t word_index(input fsab_addr_t byte_addr);
		return byte_addr[fsab_addr_lo +: idx_w];
	endfunction

	function automatic fsab_data_t merge_bytes(input fsab_data_t old_word,
			input fsab_data_t new_word, input fsab_mask_t byte_en);
		fsab_data_t merged;
		merged = old_word;
		for (int b = 0; b < fsab_bytes; b++) begin
			if (byte_en[b]) begin
				merged[b*8 +: 8] = new_word[b*8 +: 8];
			end
		end
		return merged;
	endfunction

	initial begin
		for (int w = 0; w < mem_words; w++) begin
			mem[w] = '0;
		end
	end

	assign in_load = (state == load);
	assign cur_addr = in_load ? req.addr : addr_r; // the first beat uses the header address.
	assign cur_len = in_load ? req.len : len_rem;
	assign cur_idx = word_index(cur_addr);
	assign last_beat = (cur_len == fsab_len_t'(1));
	assign wr_beat = (in_load && (req.mode == FSAB_WRITE)) || (state == write_beats);
	assign rd_beat = (in_load && (req.mode == FSAB_READ)) || (state == read_beats);

	// The first data beat always leaves with its header, even for a read.
	assign req.req_pop = (state == idle) && req.req_valid && dat.data_valid;
	assign dat.data_pop = req.req_pop || (wr_beat && !last_beat);

	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			state <= idle;
			addr_r <= '0;
			len_rem <= '0;
			fsabi_valid <= 1'b0;
		end else begin
			fsabi_valid <= rd_beat; // read data shows up one cycle after its beat.
			if (wr_beat || rd_beat) begin
				addr_r <= cur_addr + fsab_addr_t'(fsab_bytes);
				len_rem <= cur_len - fsab_len_t'(1);
			end
			case (state)
				idle: begin
					if (req.req_pop) begin
						state <= load;
					end
				end
				load: begin
					if (last_beat) begin
						state <= idle;
					end else if (req.mode == FSAB_WRITE) begin
						state <= write_beats;
					end else begin
						state <= read_beats;
					end
				end
				write_beats, read_beats: begin
					if (last_beat) begin
						state <= idle;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	always @(posedge clk) begin
		if (wr_beat) begin
			mem[cur_idx] <= merge_bytes(mem[cur_idx], dat.data, dat.mask);
		end
	end

	// Tags travel with each beat so the next header pop cannot disturb them.
	always_ff @(posedge clk) begin
		if (rd_beat) begin
			fsabi_data <= mem[cur_idx];
			fsabi_did <= req.did;
			fsabi_subdid <= req.subdid;
		end
	end

	// A zero length header would leave the beat counter wrapping through a long burst.
	a_len_nonzero: assert property (@(posedge clk) disable iff (!Nrst)
		in_load |-> (req.len != '0))
		else $error("zero length request reached the controller");

endmodule

`default_nettype wire

// File: fsab_data_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module fsab_data_fifo import fsab_pkg::*; #(
	parameter int data_depth = fsab_credits * fsab_len_max
) (
	input wire clk,
	input wire Nrst,
	input wire fsabo_valid,
	input wire fsab_data_t fsabo_data,
	input wire fsab_mask_t fsabo_mask,
	fsab_data_if.fifo dat
);

	localparam int idx_w = $clog2(data_depth);

	typedef logic [idx_w:0] ptr_t;

	ptr_t wr_ptr;
	ptr_t rd_ptr;
	logic full;
	logic empty;

	fsab_data_t data_q [data_depth];
	fsab_mask_t mask_q [data_depth];

	assign empty = (wr_ptr == rd_ptr);
	assign full = ((wr_ptr - rd_ptr) == ptr_t'(data_depth));
	assign dat.data_valid = !empty;

	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (fsabo_valid) begin
				wr_ptr <= wr_ptr + ptr_t'(1); // reads queue their dummy beat as well.
			end
			if (dat.data_pop) begin
				rd_ptr <= rd_ptr + ptr_t'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fsabo_valid) begin
			data_q[wr_ptr[idx_w-1:0]] <= fsabo_data;
			mask_q[wr_ptr[idx_w-1:0]] <= fsabo_mask;
		end
		if (dat.data_pop) begin
			dat.data <= data_q[rd_ptr[idx_w-1:0]];
			dat.mask <= mask_q[rd_ptr[idx_w-1:0]];
		end
	end

	a_no_push_full: assert property (@(posedge clk) disable iff (!Nrst)
		!(fsabo_valid && full))
		else $error("data queue written while full");

	a_no_pop_empty: assert property (@(posedge clk) disable iff (!Nrst)
		!(dat.data_pop && empty))
		else $error("data queue read while empty");

endmodule

`default_nettype wire

// File: fsab_req_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module fsab_req_fifo import fsab_pkg::*; (
	input wire clk,
	input wire Nrst,
	input wire fsabo_valid,
	input wire fsab_mode_t fsabo_mode,
	input wire fsab_did_t fsabo_did,
	input wire fsab_did_t fsabo_subdid,
	input wire fsab_addr_t fsabo_addr,
	input wire fsab_len_t fsabo_len,
	output logic fsabo_credit,
	fsab_req_if.fifo req
);

	localparam int idx_w = $clog2(fsab_credits);

	typedef logic [idx_w:0] ptr_t;

	ptr_t wr_ptr;
	ptr_t rd_ptr;
	fsab_len_t beats_rem; // beats of the current burst still to come.
	logic push;
	logic full;
	logic empty;

	fsab_mode_t mode_q [fsab_credits];
	fsab_did_t did_q [fsab_credits];
	fsab_did_t subdid_q [fsab_credits];
	fsab_addr_t addr_q [fsab_credits];
	fsab_len_t len_q [fsab_credits];

	assign push = fsabo_valid && (beats_rem == '0); // only the first beat carries a header.
	assign empty = (wr_ptr == rd_ptr);
	assign full = ((wr_ptr - rd_ptr) == ptr_t'(fsab_credits));
	assign req.req_valid = !empty;
	assign fsabo_credit = req.req_pop; // every header taken frees one credit.

	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			beats_rem <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + ptr_t'(1);
			end
			if (req.req_pop) begin
				rd_ptr <= rd_ptr + ptr_t'(1);
			end
			if (push) begin
				if (fsabo_mode == FSAB_WRITE) begin
					beats_rem <= fsabo_len - fsab_len_t'(1); // a read is always one beat.
				end else begin
					beats_rem <= '0;
				end
			end else if (fsabo_valid) begin
				beats_rem <= beats_rem - fsab_len_t'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mode_q[wr_ptr[idx_w-1:0]] <= fsabo_mode;
			did_q[wr_ptr[idx_w-1:0]] <= fsabo_did;
			subdid_q[wr_ptr[idx_w-1:0]] <= fsabo_subdid;
			addr_q[wr_ptr[idx_w-1:0]] <= fsabo_addr;
			len_q[wr_ptr[idx_w-1:0]] <= fsabo_len;
		end
		if (req.req_pop) begin
			req.mode <= mode_q[rd_ptr[idx_w-1:0]];
			req.did <= did_q[rd_ptr[idx_w-1:0]];
			req.subdid <= subdid_q[rd_ptr[idx_w-1:0]];
			req.addr <= addr_q[rd_ptr[idx_w-1:0]];
			req.len <= len_q[rd_ptr[idx_w-1:0]];
		end
	end

	// A full queue here means the master issued without holding a credit.
	a_no_push_full: assert property (@(posedge clk) disable iff (!Nrst)
		!(push && full))
		else $error("header queue written while full");

	a_no_pop_empty: assert property (@(posedge clk) disable iff (!Nrst)
		!(req.req_pop && empty))
		else $error("header queue read while empty");

endmodule

`default_nettype wire

// File: fsab_data_if.sv
`timescale 1ns/10ps
`default_nettype none

interface fsab_data_if import fsab_pkg::*; ();

	logic data_valid; // at least one beat waits in the queue.
	fsab_data_t data;
	fsab_mask_t mask; // one enable per byte of data.
	logic data_pop; // data and mask update on the cycle after this.

	modport fifo (
		output data_valid,
		output data,
		output mask,
		input data_pop
	);

	modport ctrl (
		input data_valid,
		input data,
		input mask,
		output data_pop
	);

endinterface

`default_nettype wire

// File: fsab_req_if.sv
`timescale 1ns/10ps
`default_nettype none

interface fsab_req_if import fsab_pkg::*; ();

	logic req_valid; // at least one header waits in the queue.
	fsab_mode_t mode;
	fsab_did_t did;
	fsab_did_t subdid;
	fsab_addr_t addr;
	fsab_len_t len;
	logic req_pop; // header fields update on the cycle after this.

	modport fifo (
		output req_valid,
		output mode,
		output did,
		output subdid,
		output addr,
		output len,
		input req_pop
	);

	modport ctrl (
		input req_valid,
		input mode,
		input did,
		input subdid,
		input addr,
		input len,
		output req_pop
	);

endinterface

`default_nettype wire

// File: fsab_pkg.sv
`default_nettype none

package fsab_pkg;

	localparam int fsab_did_w = 4;
	localparam int fsab_addr_w = 31;
	localparam int fsab_len_w = 4;
	localparam int fsab_data_w = 64;
	localparam int fsab_mask_w = fsab_data_w / 8;

	localparam int fsab_credits = 4; // a master starts out holding this many requests.
	localparam int fsab_len_max = 8; // longest burst in words.
	localparam int fsab_bytes = fsab_data_w / 8; // address step from one beat to the next.
	localparam int fsab_addr_lo = $clog2(fsab_bytes); // lowest address bit that picks a word.

	// Request direction, as seen from the master.
	typedef enum logic {
		FSAB_READ = 1'b0,
		FSAB_WRITE = 1'b1
	} fsab_mode_t;

	typedef logic [fsab_did_w-1:0] fsab_did_t;
	typedef logic [fsab_addr_w-1:0] fsab_addr_t;
	typedef logic [fsab_len_w-1:0] fsab_len_t;
	typedef logic [fsab_data_w-1:0] fsab_data_t;
	typedef logic [fsab_mask_w-1:0] fsab_mask_t;

	// Memory controller sequencing.
	typedef enum logic [1:0] {
		idle, // waiting for a queued header.
		load, // popped header and first beat are visible.
		write_beats, // merging the rest of a write burst.
		read_beats // streaming the rest of a read burst.
	} mem_state_t;

endpackage

`default_nettype wire
